//--- common/pixel_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream carrying one payload tagged with its pixel position
interface pixel_stream_if #(
    parameter type payload_t = prepro_pkg::pix_pair_t
);
    import prepro_pkg::*;

    logic     valid;
    logic     ready;
    payload_t payload;
    coord_t   col;
    coord_t   row;

    // producer side
    modport src (
        output valid,
        output payload,
        output col,
        output row,
        input  ready
    );

    // consumer side
    modport snk (
        input  valid,
        input  payload,
        input  col,
        input  row,
        output ready
    );

endinterface

`default_nettype wire

//--- common/prepro_defines.svh
`ifndef PREPRO_DEFINES_SVH
`define PREPRO_DEFINES_SVH

// pixel and coordinate widths
`define PREPRO_PIX_W     8
`define PREPRO_COORD_W   16

// horizontal window, box sum and signed result widths
`define PREPRO_WIN_W     3
`define PREPRO_BOX_W     10
`define PREPRO_CALC_W    12

// fp16 fields
`define PREPRO_EXP_W     5
`define PREPRO_FRAC_W    10
`define PREPRO_EXP_BIAS  15

// results are scaled by 2^-8
`define PREPRO_SCALE_EXP (-8)

`endif

//--- common/prepro_pkg.sv
`default_nettype none

`include "prepro_defines.svh"

package prepro_pkg;

    // ----------------------------------------------------------
    // pixel level types
    typedef logic [`PREPRO_PIX_W-1:0]   pixel_t;
    typedef logic [`PREPRO_COORD_W-1:0] coord_t;

    // zipped pair, plus channel in the upper byte
    typedef struct packed {
        pixel_t plus;
        pixel_t minus;
    } pix_pair_t;

    // index 0 holds the oldest column
    typedef pix_pair_t [`PREPRO_WIN_W-1:0] win_pair_t;

    // ----------------------------------------------------------
    // arithmetic types
    typedef logic signed [`PREPRO_CALC_W-1:0] calc_t;

    typedef struct packed {
        calc_t i_a;
        calc_t i_t;
    } ia_it_t;

    // ----------------------------------------------------------
    // half precision result
    typedef struct packed {
        logic                      sign;
        logic [`PREPRO_EXP_W-1:0]  exp;
        logic [`PREPRO_FRAC_W-1:0] frac;
    } fp16_t;

endpackage

`default_nettype wire

//--- sim.f
+incdir+common
common/prepro_pkg.sv
common/pixel_stream_if.sv
source/pixel_window.sv
source/box_sum.sv
source/fp16_pack.sv
source/prepro_core.sv
testbench/tb_prepro_core.sv

//--- source/box_sum.sv
`timescale 1ns/1ps
`default_nettype none

`include "prepro_defines.svh"

module box_sum (
    input  wire logic   clk_i,
    input  wire logic   i_rst_n,
    pixel_stream_if.snk i_win,
    pixel_stream_if.src o_sum
);
    import prepro_pkg::*;

    localparam int EXT_W = `PREPRO_CALC_W - `PREPRO_BOX_W;

    logic [`PREPRO_BOX_W-1:0] box_plus;
    logic [`PREPRO_BOX_W-1:0] box_minus;
    calc_t                    plus_ext;
    calc_t                    minus_ext;
    ia_it_t                   sum_d;
    ia_it_t                   sum_q;
    coord_t                   col_q;
    coord_t                   row_q;
    logic                     valid_q;
    logic                     accept;

    assign i_win.ready = !valid_q || o_sum.ready;
    assign accept      = i_win.valid && i_win.ready;

    // 1x3 box per channel
    always_comb begin
        box_plus  = '0;
        box_minus = '0;
        for (int k = 0; k < `PREPRO_WIN_W; k++) begin
            box_plus  = box_plus + i_win.payload[k].plus;
            box_minus = box_minus + i_win.payload[k].minus;
        end
    end

    assign plus_ext  = {{EXT_W{1'b0}}, box_plus};
    assign minus_ext = {{EXT_W{1'b0}}, box_minus};
    assign sum_d.i_a = plus_ext + minus_ext;
    assign sum_d.i_t = plus_ext - minus_ext;

    always_ff @(posedge clk_i) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_win.ready) begin
            valid_q <= i_win.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            sum_q <= sum_d;
            col_q <= i_win.col;
            row_q <= i_win.row;
        end
    end

    assign o_sum.valid   = valid_q;
    assign o_sum.payload = sum_q;
    assign o_sum.col     = col_q;
    assign o_sum.row     = row_q;

    // intensity is non-negative and bounds the difference
    a_sum_range: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        valid_q |-> (sum_q.i_a >= 0) && (sum_q.i_t <= sum_q.i_a) && (-sum_q.i_t <= sum_q.i_a));

endmodule

`default_nettype wire

//--- source/fp16_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "prepro_defines.svh"

module fp16_pack (
    input  wire logic          clk_i,
    input  wire logic          i_rst_n,
    pixel_stream_if.snk        i_sum,
    output logic               o_valid,
    output prepro_pkg::fp16_t  o_i_a,
    output prepro_pkg::fp16_t  o_i_t,
    output prepro_pkg::coord_t o_col,
    output prepro_pkg::coord_t o_row,
    input  wire logic          i_ready
);
    import prepro_pkg::*;

    localparam int EXP_MIN = `PREPRO_EXP_BIAS + `PREPRO_SCALE_EXP;
    localparam int EXP_MAX = EXP_MIN + `PREPRO_FRAC_W;

    // exact conversion, magnitude always fits the mantissa
    function automatic fp16_t to_fp16(input calc_t v);
        logic [`PREPRO_CALC_W-1:0]                mag;
        logic [`PREPRO_CALC_W+`PREPRO_FRAC_W-1:0] aligned;
        int                                       lead;
        int                                       exp_val;
        fp16_t                                    res;
        res  = '0;
        mag  = v[`PREPRO_CALC_W-1] ? -v : v;
        lead = 0;
        for (int i = 0; i < `PREPRO_CALC_W; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        exp_val = lead + EXP_MIN;
        aligned = {{`PREPRO_FRAC_W{1'b0}}, mag} << (`PREPRO_FRAC_W - lead);
        if (mag != '0) begin
            res.sign = v[`PREPRO_CALC_W-1];
            res.exp  = exp_val[`PREPRO_EXP_W-1:0];
            res.frac = aligned[`PREPRO_FRAC_W-1:0];
        end
        return res;
    endfunction

    assign i_sum.ready = !o_valid || i_ready;

    always_ff @(posedge clk_i) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_sum.ready) begin
            o_valid <= i_sum.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (i_sum.valid && i_sum.ready) begin
            o_i_a <= to_fp16(i_sum.payload.i_a);
            o_i_t <= to_fp16(i_sum.payload.i_t);
            o_col <= i_sum.col;
            o_row <= i_sum.row;
        end
    end

    a_exp_range: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        o_valid |-> ((o_i_a.exp == '0) || (o_i_a.exp inside {[EXP_MIN:EXP_MAX]}))
            && ((o_i_t.exp == '0) || (o_i_t.exp inside {[EXP_MIN:EXP_MAX]})));

endmodule

`default_nettype wire

//--- source/pixel_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "prepro_defines.svh"

module pixel_window (
    input  wire logic                  clk_i,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_valid,
    input  wire prepro_pkg::pix_pair_t i_pair,
    input  wire prepro_pkg::coord_t    i_col,
    input  wire prepro_pkg::coord_t    i_row,
    output logic                       o_ready,
    pixel_stream_if.src                o_win
);
    import prepro_pkg::*;

    localparam int HIST_D = `PREPRO_WIN_W - 1;
    localparam int CENTRE = `PREPRO_WIN_W / 2;

    pix_pair_t [HIST_D-1:0] hist_q;
    win_pair_t              win_q;
    coord_t                 col_q;
    coord_t                 row_q;
    logic                   valid_q;
    logic                   accept;
    logic                   full_win;

    // last accepted position, for the column order check
    coord_t last_col_q;
    coord_t last_row_q;
    logic   seen_q;

    assign o_ready  = !valid_q || o_win.ready;
    assign accept   = i_valid && o_ready;
    assign full_win = (i_col >= coord_t'(HIST_D));

    always_ff @(posedge clk_i) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            seen_q  <= 1'b0;
        end else begin
            if (o_ready) begin
                valid_q <= accept && full_win;
            end
            if (accept) begin
                seen_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // shifter and window register
    always_ff @(posedge clk_i) begin
        if (accept) begin
            hist_q     <= {i_pair, hist_q[HIST_D-1:1]};
            last_col_q <= i_col;
            last_row_q <= i_row;
            if (full_win) begin
                win_q <= {i_pair, hist_q};
                col_q <= i_col - coord_t'(CENTRE);
                row_q <= i_row;
            end
        end
    end

    assign o_win.valid   = valid_q;
    assign o_win.payload = win_q;
    assign o_win.col     = col_q;
    assign o_win.row     = row_q;

    // columns arrive in order, each row starting at 0
    a_col_order: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        accept |-> (i_col == '0)
            || (seen_q && (i_row == last_row_q) && (i_col == coord_t'(last_col_q + 1'b1))));

    // upstream keeps its pixel while stalled
    a_in_hold: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        i_valid && !o_ready |=> i_valid && $stable(i_pair) && $stable(i_col)
            && $stable(i_row));

endmodule

`default_nettype wire

//--- source/prepro_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "prepro_defines.svh"

module prepro_core (
    input  wire logic                     clk_i,
    input  wire logic                     i_rst_n,

    // upstream pixel pairs
    input  wire logic                     i_valid,
    input  wire logic [`PREPRO_PIX_W-1:0] i_plus,
    input  wire logic [`PREPRO_PIX_W-1:0] i_minus,
    input  wire prepro_pkg::coord_t       i_col,
    input  wire prepro_pkg::coord_t       i_row,
    output logic                          o_ready,

    // downstream fp16 results
    output logic                          o_valid,
    output prepro_pkg::fp16_t             o_i_a,
    output prepro_pkg::fp16_t             o_i_t,
    output prepro_pkg::coord_t            o_col,
    output prepro_pkg::coord_t            o_row,
    input  wire logic                     i_ready
);
    import prepro_pkg::*;

    pix_pair_t in_pair;

    pixel_stream_if #(.payload_t(win_pair_t)) win_s ();
    pixel_stream_if #(.payload_t(ia_it_t))    sum_s ();

    // zip, plus channel in the upper byte
    assign in_pair.plus  = i_plus;
    assign in_pair.minus = i_minus;

    // ----------------------------------------------------------
    // decode
    pixel_window u_pixel_window (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_valid(i_valid),
        .i_pair (in_pair),
        .i_col  (i_col),
        .i_row  (i_row),
        .o_ready(o_ready),
        .o_win  (win_s.src)
    );

    // ----------------------------------------------------------
    // execute
    box_sum u_box_sum (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_win  (win_s.snk),
        .o_sum  (sum_s.src)
    );

    // ----------------------------------------------------------
    // result
    fp16_pack u_fp16_pack (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_sum  (sum_s.snk),
        .o_valid(o_valid),
        .o_i_a  (o_i_a),
        .o_i_t  (o_i_t),
        .o_col  (o_col),
        .o_row  (o_row),
        .i_ready(i_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_prepro_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "prepro_defines.svh"

module tb_prepro_core;
    import prepro_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int IMG_W      = 8;
    localparam int IMG_H      = 6;
    localparam int N_PIX      = IMG_W * IMG_H;
    localparam int N_OUT      = (IMG_W - 2) * IMG_H;
    localparam int EQUAL_ROW  = 2;
    // i_ready held high while these pixels are fed
    localparam int HOLD_LO    = 24;
    localparam int HOLD_HI    = 40;

    typedef struct packed {
        fp16_t       i_a;
        fp16_t       i_t;
        coord_t      col;
        coord_t      row;
        logic        timed;
        logic [63:0] acc_t;
    } exp_item_t;

    logic   clk_i;
    logic   i_rst_n;
    logic   i_valid;
    pixel_t i_plus;
    pixel_t i_minus;
    coord_t i_col;
    coord_t i_row;
    logic   o_ready;
    logic   o_valid;
    fp16_t  o_i_a;
    fp16_t  o_i_t;
    coord_t o_col;
    coord_t o_row;
    logic   i_ready;

    logic [31:0] lfsr_q;
    pixel_t      plus_mem [0:N_PIX-1];
    pixel_t      minus_mem [0:N_PIX-1];
    exp_item_t   exp_q [$];
    logic        in_acc;
    int          out_count;
    int          mis_count;
    int          fail_count;

    prepro_core u_prepro_core (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_valid(i_valid),
        .i_plus (i_plus),
        .i_minus(i_minus),
        .i_col  (i_col),
        .i_row  (i_row),
        .o_ready(o_ready),
        .o_valid(o_valid),
        .o_i_a  (o_i_a),
        .o_i_t  (o_i_t),
        .o_col  (o_col),
        .o_row  (o_row),
        .i_ready(i_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // random bits and reference model
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[6:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic fp16_t ref_fp16(input calc_t v);
        fp16_t r;
        int    m;
        int    p;
        r = '0;
        if (v != 0) begin
            m = (v < 0) ? -int'(v) : int'(v);
            p = 0;
            while ((m >> (p + 1)) != 0) begin
                p++;
            end
            r.sign = (v < 0);
            r.exp  = `PREPRO_EXP_W'(p + `PREPRO_EXP_BIAS + `PREPRO_SCALE_EXP);
            r.frac = `PREPRO_FRAC_W'((m - (1 << p)) << (`PREPRO_FRAC_W - p));
        end
        return r;
    endfunction

    task automatic accept_pixel(input int idx);
        int        sp;
        int        sm;
        int        c;
        exp_item_t e;
        c = idx % IMG_W;
        if (c >= 2) begin
            sp      = int'(plus_mem[idx-2]) + int'(plus_mem[idx-1]) + int'(plus_mem[idx]);
            sm      = int'(minus_mem[idx-2]) + int'(minus_mem[idx-1]) + int'(minus_mem[idx]);
            e.i_a   = ref_fp16(calc_t'(sp + sm));
            e.i_t   = ref_fp16(calc_t'(sp - sm));
            e.col   = coord_t'(c - 1);
            e.row   = coord_t'(idx / IMG_W);
            e.timed = (idx >= HOLD_LO) && (idx < HOLD_LO + 12);
            e.acc_t = $time;
            exp_q.push_back(e);
        end
    endtask

    // ------------------------------------------------------------
    // compare tasks
    task automatic check_fp16(input fp16_t got, input fp16_t exp, input string what);
        if (got !== exp) begin
            mis_count++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        if (got !== exp) begin
            mis_count++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mis_count++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // input handshake sampled away from the clock edge
    always @(negedge clk_i) begin
        in_acc = i_valid && o_ready;
    end

    // output scoreboard
    initial begin : scoreboard
        logic        stall_q;
        fp16_t       held_a;
        fp16_t       held_t;
        coord_t      held_col;
        coord_t      held_row;
        logic [63:0] valid_since;
        exp_item_t   e;
        stall_q     = 1'b0;
        valid_since = '0;
        forever begin
            @(negedge clk_i);
            if (i_rst_n) begin
                if (stall_q) begin
                    check_bit(o_valid, 1'b1, "o_valid under stall");
                    check_fp16(o_i_a, held_a, "o_i_a under stall");
                    check_fp16(o_i_t, held_t, "o_i_t under stall");
                    check_coord(o_col, held_col, "o_col under stall");
                    check_coord(o_row, held_row, "o_row under stall");
                end else if (o_valid) begin
                    // first edge that samples this result
                    valid_since = $time + CLK_PERIOD / 2;
                end
                if (o_valid && i_ready) begin
                    out_count++;
                    if (exp_q.size() == 0) begin
                        fail_count++;
                        $display("output transfer at %0t ns with no result expected", $time);
                    end else begin
                        e = exp_q.pop_front();
                        check_fp16(o_i_a, e.i_a, "o_i_a");
                        check_fp16(o_i_t, e.i_t, "o_i_t");
                        check_coord(o_col, e.col, "o_col");
                        check_coord(o_row, e.row, "o_row");
                        if (e.timed && (valid_since != e.acc_t + 3 * CLK_PERIOD)) begin
                            fail_count++;
                            $display("result for col %0d row %0d came %0d ns after input, not %0d",
                                     e.col, e.row, valid_since - e.acc_t, 3 * CLK_PERIOD);
                        end
                    end
                end
                stall_q  = o_valid && !i_ready;
                held_a   = o_i_a;
                held_t   = o_i_t;
                held_col = o_col;
                held_row = o_row;
            end
        end
    end

    initial begin : watchdog
        #(20 * N_PIX * CLK_PERIOD);
        $display("timeout: only %0d of %0d results seen", out_count, N_OUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // reset and stimulus
    initial begin : driver
        int   idx;
        logic pending;
        logic hold;
        lfsr_q     = 32'h9c9d920a;
        out_count  = 0;
        mis_count  = 0;
        fail_count = 0;
        in_acc     = 1'b0;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_plus     = '0;
        i_minus    = '0;
        i_col      = '0;
        i_row      = '0;
        i_ready    = 1'b1;
        repeat (10) begin
            @(negedge clk_i);
            check_bit(o_valid, 1'b0, "o_valid in reset");
            check_bit(o_ready, 1'b1, "o_ready in reset");
        end
        @(posedge clk_i);
        i_rst_n <= 1'b1;
        @(negedge clk_i);
        check_bit(o_valid, 1'b0, "o_valid after reset");
        check_bit(o_ready, 1'b1, "o_ready after reset");

        idx     = 0;
        pending = 1'b0;
        while (idx < N_PIX || out_count < N_OUT) begin
            @(posedge clk_i);
            if (pending && in_acc) begin
                accept_pixel(idx);
                idx++;
                pending = 1'b0;
            end
            hold = (idx >= HOLD_LO) && (idx < HOLD_HI);
            i_ready <= hold ? 1'b1 : (rand_bits(2) != 0);
            if (!pending && idx < N_PIX) begin
                if (rand_bits(2) == 0) begin
                    i_valid <= 1'b0;
                end else begin
                    plus_mem[idx]  = rand_bits(8);
                    minus_mem[idx] = (idx / IMG_W == EQUAL_ROW) ? plus_mem[idx] : rand_bits(8);
                    pending        = 1'b1;
                    i_valid <= 1'b1;
                    i_plus  <= plus_mem[idx];
                    i_minus <= minus_mem[idx];
                    i_col   <= coord_t'(idx % IMG_W);
                    i_row   <= coord_t'(idx / IMG_W);
                end
            end else if (!pending) begin
                i_valid <= 1'b0;
            end
        end

        // drain, anything extra is a duplicate
        i_ready <= 1'b1;
        repeat (5) @(negedge clk_i);
        if (out_count != N_OUT || exp_q.size() != 0) begin
            fail_count++;
            $display("wrong number of results: %0d seen, %0d expected", out_count, N_OUT);
        end
        $display("%0d results, %0d mismatches, %0d other errors",
                 out_count, mis_count, fail_count);
        if (mis_count == 0 && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
